/* common/cpuPkg.sv */
package cpuPkg;

    // ========================================================================
    // widths
    // ========================================================================

    localparam int unsigned wordSize    = 16;
    localparam int unsigned regAddrSize = 2;
    localparam int unsigned controlSize = 12;

    // ========================================================================
    // opcodes, instruction bits 15:12
    // ========================================================================

    localparam logic [3:0] opBne   = 4'd0;
    localparam logic [3:0] opBeq   = 4'd1;
    localparam logic [3:0] opBgz   = 4'd2;
    localparam logic [3:0] opBlz   = 4'd3;
    localparam logic [3:0] opAdi   = 4'd4;
    localparam logic [3:0] opOri   = 4'd5;
    localparam logic [3:0] opLhi   = 4'd6;
    localparam logic [3:0] opLwd   = 4'd7;
    localparam logic [3:0] opSwd   = 4'd8;
    localparam logic [3:0] opJmp   = 4'd9;
    localparam logic [3:0] opJal   = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // R-type function field, bits 5:0
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnHlt = 6'd29;

    // ========================================================================
    // ALU operations
    // ========================================================================

    localparam logic [3:0] aluAdd = 4'd0;
    localparam logic [3:0] aluSub = 4'd1;
    localparam logic [3:0] aluAnd = 4'd2;
    localparam logic [3:0] aluOr  = 4'd3;
    localparam logic [3:0] aluNot = 4'd4;
    localparam logic [3:0] aluTcp = 4'd5;
    localparam logic [3:0] aluShl = 4'd6;
    localparam logic [3:0] aluShr = 4'd7;
    localparam logic [3:0] aluLhi = 4'd8; // imm into upper byte

    // control word layout
    localparam int unsigned ctlJump     = 11;
    localparam int unsigned ctlBranch   = 10;
    localparam int unsigned ctlMemToReg = 9;
    localparam int unsigned ctlMemRead  = 8;
    localparam int unsigned ctlMemWrite = 7;
    localparam int unsigned ctlRegDst   = 6;
    localparam int unsigned ctlRegWrite = 5;
    localparam int unsigned ctlAluOpMsb = 4;
    localparam int unsigned ctlAluOpLsb = 1;
    localparam int unsigned ctlAluSrc   = 0;

    localparam logic [1:0] linkRegister = 2'd2; // return address for JAL/JRL

endpackage

/* source/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpuPkg::regAddrSize-1:0] readIndex1,
    input  logic [cpuPkg::regAddrSize-1:0] readIndex2,
    input  logic [cpuPkg::regAddrSize-1:0] writeIndex,
    input  logic [cpuPkg::wordSize-1:0]    writeData,
    input  logic                           writeEnable,
    output logic [cpuPkg::wordSize-1:0]    readData1,
    output logic [cpuPkg::wordSize-1:0]    readData2
);
    import cpuPkg::*;

    logic [wordSize-1:0] regs [2**regAddrSize];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrSize; i++)
                regs[i] <= '0;
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    // combinational reads, no bypass
    assign readData1 = regs[readIndex1];
    assign readData2 = regs[readIndex2];

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::wordSize-1:0] a,
    input  logic [cpuPkg::wordSize-1:0] b,
    input  logic [3:0]                  op,
    output logic [cpuPkg::wordSize-1:0] result,
    output logic                        isZero,
    output logic                        isNegative
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluNot: result = ~a;
            aluTcp: result = ~a + 16'd1;   // negate
            aluShl: result = {a[wordSize-2:0], 1'b0};
            aluShr: result = {a[wordSize-1], a[wordSize-1:1]}; // keeps sign
            aluLhi: result = {b[7:0], 8'h00};
            default: result = '0;
        endcase
    end

    // flags follow the result
    assign isZero     = (result == '0);
    assign isNegative = result[wordSize-1];

endmodule

/* cpu/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
    input  logic [3:0]                     opcode,
    input  logic [5:0]                     func,
    output logic [cpuPkg::controlSize-1:0] controls
);
    import cpuPkg::*;

    logic [controlSize-1:0] ctl;

    always_comb begin
        ctl = '0;
        case (opcode)
            opBne, opBeq, opBgz, opBlz: begin
                ctl[ctlBranch] = 1'b1;
                ctl[ctlAluOpMsb:ctlAluOpLsb] = aluSub; // flags drive the decision
            end
            opAdi: begin
                ctl[ctlRegWrite] = 1'b1;
                ctl[ctlAluSrc]   = 1'b1;
                ctl[ctlAluOpMsb:ctlAluOpLsb] = aluAdd;
            end
            opOri: begin
                ctl[ctlRegWrite] = 1'b1;
                ctl[ctlAluSrc]   = 1'b1;
                ctl[ctlAluOpMsb:ctlAluOpLsb] = aluOr;
            end
            opLhi: begin
                ctl[ctlRegWrite] = 1'b1;
                ctl[ctlAluSrc]   = 1'b1;
                ctl[ctlAluOpMsb:ctlAluOpLsb] = aluLhi;
            end
            opLwd: begin
                ctl[ctlMemRead]  = 1'b1;
                ctl[ctlMemToReg] = 1'b1;
                ctl[ctlRegWrite] = 1'b1;
                ctl[ctlAluSrc]   = 1'b1;
                ctl[ctlAluOpMsb:ctlAluOpLsb] = aluAdd; // base + offset
            end
            opSwd: begin
                ctl[ctlMemWrite] = 1'b1;
                ctl[ctlAluSrc]   = 1'b1;
                ctl[ctlAluOpMsb:ctlAluOpLsb] = aluAdd;
            end
            opJmp: ctl[ctlJump] = 1'b1;
            opJal: begin
                ctl[ctlJump]     = 1'b1;
                ctl[ctlRegWrite] = 1'b1; // link register
            end
            opRtype: begin
                // ==============================================================
                // R-type, decoded by func
                // ==============================================================
                case (func)
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        ctl[ctlRegDst]   = 1'b1;
                        ctl[ctlRegWrite] = 1'b1;
                        ctl[ctlAluOpMsb:ctlAluOpLsb] = func[3:0]; // same encoding
                    end
                    fnJpr: ctl[ctlJump] = 1'b1;
                    fnJrl: begin
                        ctl[ctlJump]     = 1'b1;
                        ctl[ctlRegWrite] = 1'b1;
                    end
                    default: ctl = '0; // HLT and unused codes
                endcase
            end
            default: ctl = '0;
        endcase
    end

    assign controls = ctl;

endmodule

/* cpu/cpuDatapath.sv */
`timescale 1ns/1ps

module cpuDatapath (
    input  logic                            clk,
    input  logic                            reset,
    // memory port
    input  logic [cpuPkg::wordSize-1:0]     readData,
    input  logic                            inputReady,
    input  logic                            ackOutput,
    input  logic [cpuPkg::controlSize-1:0]  controls,
    output logic                            readM,
    output logic                            writeM,
    output logic [cpuPkg::wordSize-1:0]     address,
    output logic [cpuPkg::wordSize-1:0]     writeData,
    output logic                            halted,
    // register file
    output logic [cpuPkg::regAddrSize-1:0]  readIndex1,
    output logic [cpuPkg::regAddrSize-1:0]  readIndex2,
    output logic [cpuPkg::regAddrSize-1:0]  writeIndex,
    output logic [cpuPkg::wordSize-1:0]     regWriteData,
    output logic                            regWrite,
    input  logic [cpuPkg::wordSize-1:0]     readData1,
    input  logic [cpuPkg::wordSize-1:0]     readData2,
    // ALU
    output logic [cpuPkg::wordSize-1:0]     aluA,
    output logic [cpuPkg::wordSize-1:0]     aluB,
    output logic [3:0]                      aluOp,
    input  logic [cpuPkg::wordSize-1:0]     aluResult,
    input  logic                            isZero,
    input  logic                            isNegative,
    output logic [3:0]                      opcode,
    output logic [5:0]                      func
);
    import cpuPkg::*;

    typedef enum logic [1:0] {sFetch, sExecute, sMemory, sHalt} stateType;

    stateType            state;
    logic [wordSize-1:0] pc;
    logic [wordSize-1:0] ir;
    logic [wordSize-1:0] pcPlus1;
    logic [wordSize-1:0] immExt;
    logic [wordSize-1:0] nextPc;
    logic                isHalt;
    logic                signTest;
    logic                taken;

    // ========================================================================
    // instruction fields and operand selection
    // ========================================================================

    assign opcode     = ir[15:12];
    assign func       = ir[5:0];
    assign readIndex1 = ir[11:10]; // rs
    assign readIndex2 = ir[9:8];   // rt
    assign immExt     = {{8{ir[7]}}, ir[7:0]};
    assign pcPlus1    = pc + 16'd1;
    assign isHalt     = (opcode == opRtype) && (func == fnHlt);

    // BGZ/BLZ compare rs against zero
    assign signTest = (opcode == opBgz) || (opcode == opBlz);

    assign aluA  = readData1;
    assign aluB  = controls[ctlAluSrc] ? immExt :
                   (controls[ctlBranch] && signTest) ? '0 : readData2;
    assign aluOp = controls[ctlAluOpMsb:ctlAluOpLsb];

    assign writeIndex = controls[ctlJump]   ? linkRegister :
                        controls[ctlRegDst] ? ir[7:6] : ir[9:8];
    assign regWriteData = controls[ctlJump]     ? pcPlus1  :
                          controls[ctlMemToReg] ? readData : aluResult;

    // loads write back in the cycle the data arrives
    assign regWrite = (state == sExecute && controls[ctlRegWrite] && !controls[ctlMemRead]) ||
                      (state == sMemory && controls[ctlMemRead] && inputReady);

    always_comb begin
        case (opcode)
            opBne:   taken = !isZero;
            opBeq:   taken = isZero;
            opBgz:   taken = !isZero && !isNegative;
            opBlz:   taken = isNegative;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        nextPc = pcPlus1;
        if (controls[ctlJump]) begin
            if (opcode == opRtype)
                nextPc = readData1; // JPR, JRL
            else
                nextPc = {pc[15:12], ir[11:0]};
        end else if (controls[ctlBranch] && taken) begin
            nextPc = pcPlus1 + immExt;
        end
    end

    // ========================================================================
    // sequencer
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= sFetch;
            pc     <= '0;
            readM  <= 1'b0;
            writeM <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                sFetch: begin
                    if (!readM) begin
                        readM <= 1'b1; // address follows in the same edge
                    end else if (inputReady) begin
                        readM <= 1'b0;
                        state <= sExecute;
                    end
                end
                sExecute: begin
                    if (isHalt) begin
                        halted <= 1'b1;
                        state  <= sHalt;
                    end else if (controls[ctlMemRead]) begin
                        readM <= 1'b1;
                        state <= sMemory;
                    end else if (controls[ctlMemWrite]) begin
                        writeM <= 1'b1;
                        state  <= sMemory;
                    end else begin
                        pc    <= nextPc;
                        state <= sFetch;
                    end
                end
                sMemory: begin
                    if ((readM && inputReady) || (writeM && ackOutput)) begin
                        readM  <= 1'b0;
                        writeM <= 1'b0;
                        pc     <= pcPlus1;
                        state  <= sFetch;
                    end
                end
                default: state <= sHalt; // stays here
            endcase
        end
    end

    // instruction and memory payload
    always_ff @(posedge clk) begin
        if (state == sFetch && readM && inputReady)
            ir <= readData;
        if (state == sFetch && !readM) begin
            address <= pc;
        end else if (state == sExecute && (controls[ctlMemRead] || controls[ctlMemWrite])) begin
            address   <= aluResult;
            writeData <= readData2;
        end
    end

endmodule

/* cpu/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [cpuPkg::wordSize-1:0] readData,
    input  logic                        inputReady,
    input  logic                        ackOutput,
    output logic                        readM,
    output logic                        writeM,
    output logic [cpuPkg::wordSize-1:0] address,
    output logic [cpuPkg::wordSize-1:0] writeData,
    output logic                        halted
);
    import cpuPkg::*;

    logic [controlSize-1:0] controls;
    logic [3:0]             opcode;
    logic [5:0]             func;

    // register file side
    logic [regAddrSize-1:0] readIndex1;
    logic [regAddrSize-1:0] readIndex2;
    logic [regAddrSize-1:0] writeIndex;
    logic [wordSize-1:0]    regWriteData;
    logic                   regWrite;
    logic [wordSize-1:0]    readData1;
    logic [wordSize-1:0]    readData2;

    // ALU side
    logic [wordSize-1:0]    aluA;
    logic [wordSize-1:0]    aluB;
    logic [3:0]             aluOp;
    logic [wordSize-1:0]    aluResult;
    logic                   isZero;
    logic                   isNegative;

    cpuControl control0 (
        .opcode   (opcode),
        .func     (func),
        .controls (controls)
    );

    cpuDatapath datapath0 (
        .clk          (clk),
        .reset        (reset),
        .readData     (readData),
        .inputReady   (inputReady),
        .ackOutput    (ackOutput),
        .controls     (controls),
        .readM        (readM),
        .writeM       (writeM),
        .address      (address),
        .writeData    (writeData),
        .halted       (halted),
        .readIndex1   (readIndex1),
        .readIndex2   (readIndex2),
        .writeIndex   (writeIndex),
        .regWriteData (regWriteData),
        .regWrite     (regWrite),
        .readData1    (readData1),
        .readData2    (readData2),
        .aluA         (aluA),
        .aluB         (aluB),
        .aluOp        (aluOp),
        .aluResult    (aluResult),
        .isZero       (isZero),
        .isNegative   (isNegative),
        .opcode       (opcode),
        .func         (func)
    );

    registerFile regFile0 (
        .clk         (clk),
        .reset       (reset),
        .readIndex1  (readIndex1),
        .readIndex2  (readIndex2),
        .writeIndex  (writeIndex),
        .writeData   (regWriteData),
        .writeEnable (regWrite),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    alu alu0 (
        .a          (aluA),
        .b          (aluB),
        .op         (aluOp),
        .result     (aluResult),
        .isZero     (isZero),
        .isNegative (isNegative)
    );

endmodule

/* testbench/memoryModel.sv */
`timescale 1ns/1ps

module memoryModel (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        readM,
    input  logic                        writeM,
    input  logic [cpuPkg::wordSize-1:0] address,
    input  logic [cpuPkg::wordSize-1:0] writeData,
    output logic [cpuPkg::wordSize-1:0] readData,
    output logic                        inputReady,
    output logic                        ackOutput
);
    import cpuPkg::*;

    localparam int unsigned seed     = 78806;
    localparam int unsigned maxDelay = 5;

    logic [wordSize-1:0] words [256]; // loaded by the testbench
    logic [wordSize-1:0] badAccesses; // requests above the modeled words

    logic                busy;
    logic                isRead;
    logic [7:0]          index;
    logic [wordSize-1:0] data;
    int unsigned         waitCount;
    int unsigned         seedValue;

    initial begin
        readData    = '0;
        inputReady  = 1'b0;
        ackOutput   = 1'b0;
        busy        = 1'b0;
        badAccesses = '0;
        waitCount   = 0;
        seedValue   = seed;
        void'($urandom(seedValue));
        forever begin
            @(posedge clk);
            isRead = readM;
            index  = address[7:0];
            data   = writeData;
            if (reset || inputReady || ackOutput) begin
                busy = 1'b0; // core drops the request on this edge
                #1;
                inputReady = 1'b0;
                ackOutput  = 1'b0;
            end else if (readM || writeM) begin
                if (!busy) begin
                    busy      = 1'b1;
                    waitCount = $urandom % (maxDelay + 1);
                    if (address[wordSize-1:8] != '0) begin
                        $display("memory request at %h lies outside the modeled words", address);
                        badAccesses++;
                    end
                end
                if (waitCount == 0) begin
                    busy = 1'b0;
                    #1;
                    if (isRead) begin
                        readData   = words[index];
                        inputReady = 1'b1;
                    end else begin
                        words[index] = data;
                        ackOutput    = 1'b1;
                    end
                end else begin
                    waitCount--; // back-pressure
                end
            end
        end
    end

endmodule

/* testbench/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int unsigned haltTimeout = 2000;
    localparam int unsigned idleCycles  = 20;

    logic                clk;
    logic                reset;
    logic [wordSize-1:0] readData;
    logic [wordSize-1:0] address;
    logic [wordSize-1:0] writeData;
    logic                inputReady;
    logic                ackOutput;
    logic                readM;
    logic                writeM;
    logic                halted;

    // one entry per memory word of the case file
    logic [127:0]        testNames [$];
    int                  entryTest [$];
    logic                entryIsExpect [$];
    logic [wordSize-1:0] entryAddr [$];
    logic [wordSize-1:0] entryWord [$];

    int errorCount;
    int passCount;
    int failCount;

    cpuCore dut0 (
        .clk        (clk),
        .reset      (reset),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .halted     (halted)
    );

    memoryModel mem0 (
        .clk        (clk),
        .reset      (reset),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input logic [wordSize-1:0] got,
                              input logic [wordSize-1:0] expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] time %0t: %0s is %h, expected %h", $time, what, got, expected);
            errorCount++;
        end
    endtask

    // ========================================================================
    // case file reader for test, mem and exp entries
    // ========================================================================

    task automatic readCases();
        int                  fd;
        int                  code;
        int                  c;
        int                  count;
        logic [127:0]        tag;
        logic [127:0]        name;
        logic [wordSize-1:0] base;
        logic [wordSize-1:0] value;
        fd = $fopen("testbench/cpuCases.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/cpuCases.txt");
            errorCount++;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    c = 0;
                    while (c != 10 && c != -1)
                        c = $fgetc(fd); // rest of the comment
                end else if (tag == "test") begin
                    code = $fscanf(fd, "%s", name);
                    if (code != 1) begin
                        $display("a test entry in the case file has no name");
                        errorCount++;
                    end
                    testNames.push_back(name);
                end else if (tag == "mem" || tag == "exp") begin
                    code = $fscanf(fd, "%h %d", base, count);
                    if (code != 2) begin
                        $display("a %0s entry in the case file lacks its address or count", tag);
                        errorCount++;
                        count = 0;
                    end
                    for (int k = 0; k < count; k++) begin
                        code = $fscanf(fd, "%h", value);
                        if (code != 1) begin
                            $display("a %0s entry in the case file is missing words", tag);
                            errorCount++;
                        end
                        entryTest.push_back(testNames.size() - 1);
                        entryIsExpect.push_back(tag == "exp");
                        entryAddr.push_back(base + k);
                        entryWord.push_back(value);
                    end
                end else begin
                    $display("unknown entry %0s in the case file", tag);
                    errorCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runTest(input int t);
        int startErrors;
        int cycles;
        startErrors = errorCount;
        for (int i = 0; i < 256; i++)
            mem0.words[i] = {i[7:0], ~i[7:0]}; // fill pattern
        for (int i = 0; i < entryTest.size(); i++) begin
            if (entryTest[i] == t && !entryIsExpect[i])
                mem0.words[entryAddr[i][7:0]] = entryWord[i];
        end
        mem0.badAccesses = '0;
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        cycles = 0;
        while (!halted && cycles < haltTimeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("test %0s: core never halted within %0d cycles", testNames[t], haltTimeout);
            failCount++;
        end else begin
            repeat (idleCycles) begin // halt must be permanent and quiet
                @(posedge clk);
                #1;
                checkValue(halted, 1'b1, "halted");
                checkValue(readM, 1'b0, "readM");
                checkValue(writeM, 1'b0, "writeM");
            end
            for (int i = 0; i < entryTest.size(); i++) begin
                if (entryTest[i] == t && entryIsExpect[i])
                    checkValue(mem0.words[entryAddr[i][7:0]], entryWord[i],
                               $sformatf("word at %h", entryAddr[i]));
            end
            checkValue(mem0.badAccesses, '0, "requests outside memory");
            if (errorCount == startErrors) begin
                $display("test %0s: pass", testNames[t]);
                passCount++;
            end else begin
                $display("test %0s: %0d mismatches", testNames[t], errorCount - startErrors);
                failCount++;
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        readCases();
        for (int t = 0; t < testNames.size(); t++)
            runTest(t);
        $display("tests passed: %0d, failed: %0d, check errors: %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0 && testNames.size() > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* testbench/cpuCases.txt */
# columns: test <name> | mem <hex address> <count> <hex words> | exp <hex address> <count> <hex words>
# memory is filled with {addr[7:0], ~addr[7:0]} before each test

# r1 = 1234, r2 = 00ff, then r1 = 8f00 for the shift right
test aluOps
mem 0000 10 7140 7241 F6C0 8350 F6C1 8351 F6C2 8352 F6C3 8353
mem 000A 10 F6C4 8354 F6C5 8355 F6C6 8356 7142 F6C7 8357 F01D
mem 0040 3 1234 00FF 8F00
exp 0050 8 1333 1135 0034 12FF EDCB EDCC 2468 C780

# adi with -3 and -128, ori, lhi over a nonzero lower byte
test immediates
mem 0000 10 4105 46FD 8250 5B70 8351 63A5 8352 4380 8353 F01D
exp 0050 4 0002 0072 A500 FF80

# base register r1 = 0040
test loadStore
mem 0000 8 4140 7600 7703 8620 8721 7601 86FF F01D
mem 0040 4 BEEF 0123 0000 7FFF
exp 003F 2 0123 BEEF
exp 0060 2 BEEF 7FFF

# taken branches skip a store of r3, others store r1 = 5
test branches
mem 0000 10 4105 4205 43FE 1601 8350 0601 8151 0701 8352 1701
mem 000A 10 8153 2401 8354 2C01 8155 3C01 8356 3401 8157 F01D
exp 0050 8 50AF 0005 52AD 0005 54AB 0005 56A9 0005

# jal from 4, jpr back to 5, jrl from 7
test jumps
mem 0000 2 9004 8050
mem 0004 6 A008 8251 410C F41A 8252 F819
mem 000C 2 8253 F01D
exp 0050 4 50AF 0005 0005 0008

# store after hlt must not happen
test halt
mem 0000 4 4111 8150 F01D 8151
exp 0050 2 0011 51AE

/* cpu.f */
common/cpuPkg.sv
source/registerFile.sv
source/alu.sv
cpu/cpuControl.sv
cpu/cpuDatapath.sv
cpu/cpuCore.sv
testbench/memoryModel.sv
testbench/cpuTb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - common/cpuPkg.sv
  - source/registerFile.sv
  - source/alu.sv
  - cpu/cpuControl.sv
  - cpu/cpuDatapath.sv
  - cpu/cpuCore.sv
  - target: test
    files:
      - testbench/memoryModel.sv
      - testbench/cpuTb.sv
